// ==== dcache_arbiter.sv ====
`timescale 1ns/1ps

module dcache_arbiter
    import ex_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stage_valid,
    input  logic        load,
    input  logic        ops_ready,
    input  logic        flush,
    input  dcache_req_t req0,
    input  dcache_req_t req1,
    input  logic        lane0_except,
    input  logic        addr_ok,
    output dcache_req_t dcache_req,
    output logic        all_done
);

    // arb_done is also the idle state
    typedef enum logic [1:0] {
        arb_lane0,
        arb_lane1,
        arb_done
    } arb_state_t;

    arb_state_t state;
    arb_state_t state_next;
    logic       lane1_issue;
    logic       lane1_skip;
    logic       accepted;

    assign lane1_issue = ~lane0_except & ops_ready & req1.valid;
    // nothing left for lane 1 to send
    assign lane1_skip  = lane0_except | (ops_ready & ~req1.valid);

    always_comb begin
        case (state)
            arb_lane0: all_done = ~req0.valid & lane1_skip;
            arb_lane1: all_done = lane1_skip;
            default:   all_done = 1'b1;
        endcase
    end

    always_comb begin
        dcache_req = (state == arb_lane1) ? req1 : req0;
        case (state)
            arb_lane0: dcache_req.valid = stage_valid & req0.valid;
            arb_lane1: dcache_req.valid = stage_valid & lane1_issue;
            default:   dcache_req.valid = 1'b0;
        endcase
    end

    assign accepted = dcache_req.valid & addr_ok;

    always_comb begin
        state_next = state;
        if (flush) begin
            state_next = arb_done;
        end else if (load) begin
            state_next = arb_lane0;
        end else if (stage_valid) begin
            if (all_done) begin
                state_next = arb_done;
            end else if (state == arb_lane0 && (!req0.valid || accepted)) begin
                state_next = arb_lane1;
            end else if (state == arb_lane1 && accepted) begin
                state_next = arb_done;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= arb_done;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== ex_bus_pkg.sv ====
package ex_bus_pkg;

    import ex_isa_pkg::*;

    // one decoded instruction entering execute
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [15:0]     imm16;
        alu_op_t         alu_op;
        logic            src1_is_sa;
        logic            src1_is_pc;
        logic            src2_is_simm;
        logic            src2_is_zimm;
        logic            src2_is_8;
        logic            detect_overflow;
        mem_op_t         mem_op;
        logic            gr_we;
        logic [4:0]      dest;
        logic [xlen-1:0] rs_value;
        logic [xlen-1:0] rt_value;
        logic            in_except;
        exccode_t        in_exccode;
        // slot 1 only, operand comes from slot 0 result
        logic            rs_dep;
        logic            rt_dep;
    } issue_slot_t;

    // slot0 is older in program order
    typedef struct packed {
        issue_slot_t slot0;
        issue_slot_t slot1;
    } issue_pair_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] mem_addr;
        logic            except;
        exccode_t        exccode;
        logic [xlen-1:0] badvaddr;
        logic            gr_we;
        logic [4:0]      dest;
        mem_op_t         mem_op;
        logic            valid;
    } lane_out_t;

    typedef struct packed {
        logic                valid;
        logic                write;
        logic                uncache;
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
        logic [1:0]          size;
        logic [3:0]          wstrb;
        logic [xlen-1:0]     wdata;
    } dcache_req_t;

    typedef struct packed {
        lane_out_t lane0;
        lane_out_t lane1;
    } stage_out_t;

endpackage

// ==== ex_isa_pkg.sv ====
package ex_isa_pkg;

    // datapath and address width
    localparam int xlen = 32;

    // data cache address split
    localparam int tag_w    = 20;
    localparam int index_w  = 7;
    localparam int offset_w = 5;

    // kseg1, top three address bits
    localparam logic [2:0] uncache_seg = 3'b101;

    typedef enum logic [3:0] {
        alu_add,
        alu_addu,
        alu_sub,
        alu_subu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb,
        mem_lbu,
        mem_lh,
        mem_lhu,
        mem_lw,
        mem_sb,
        mem_sh,
        mem_sw
    } mem_op_t;

    // codes raised here; codes from decode pass through unchanged
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ov   = 5'd12
    } exccode_t;

endpackage

// ==== exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu
    import ex_isa_pkg::*;
(
    input  alu_op_t         alu_op,
    input  logic [15:0]     imm16,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs_value,
    input  logic [xlen-1:0] rt_value,
    input  logic            src1_is_sa,
    input  logic            src1_is_pc,
    input  logic            src2_is_simm,
    input  logic            src2_is_zimm,
    input  logic            src2_is_8,
    output logic [xlen-1:0] result,
    output logic            overflow
);

    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;

    // shift amount sits in imm16[10:6]
    assign src1 = src1_is_sa ? {{(xlen-5){1'b0}}, imm16[10:6]} :
                  src1_is_pc ? pc : rs_value;

    // constant 8 is the link offset for jal and friends
    assign src2 = src2_is_simm ? {{(xlen-16){imm16[15]}}, imm16} :
                  src2_is_zimm ? {{(xlen-16){1'b0}}, imm16} :
                  src2_is_8    ? {{(xlen-4){1'b0}}, 4'd8} : rt_value;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    always_comb begin
        case (alu_op)
            alu_add, alu_addu: result = sum;
            alu_sub, alu_subu: result = diff;
            alu_and:           result = src1 & src2;
            alu_or:            result = src1 | src2;
            alu_xor:           result = src1 ^ src2;
            alu_nor:           result = ~(src1 | src2);
            alu_slt:           result = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            alu_sltu:          result = {{(xlen-1){1'b0}}, src1 < src2};
            alu_sll:           result = src2 << src1[4:0];
            alu_srl:           result = src2 >> src1[4:0];
            alu_sra:           result = $unsigned($signed(src2) >>> src1[4:0]);
            alu_lui:           result = {src2[15:0], 16'b0};
            default:           result = '0;
        endcase
    end

    // signed overflow, trapping ops only
    always_comb begin
        case (alu_op)
            alu_add: overflow = (src1[xlen-1] == src2[xlen-1]) && (sum[xlen-1] != src1[xlen-1]);
            alu_sub: overflow = (src1[xlen-1] != src2[xlen-1]) && (diff[xlen-1] != src1[xlen-1]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

// ==== exe_lane.sv ====
`timescale 1ns/1ps

module exe_lane
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  issue_slot_t slot,
    output lane_out_t   lane,
    output dcache_req_t req
);

    logic [xlen-1:0] alu_result;
    logic            alu_overflow;
    dcache_req_t     fmt_req;
    logic [xlen-1:0] mem_addr;
    logic            addr_error;
    logic            is_store;
    logic            is_mem;
    logic            ov_exc;
    logic            except;
    exccode_t        exccode;

    exe_alu u_alu (
        .alu_op       (slot.alu_op),
        .imm16        (slot.imm16),
        .pc           (slot.pc),
        .rs_value     (slot.rs_value),
        .rt_value     (slot.rt_value),
        .src1_is_sa   (slot.src1_is_sa),
        .src1_is_pc   (slot.src1_is_pc),
        .src2_is_simm (slot.src2_is_simm),
        .src2_is_zimm (slot.src2_is_zimm),
        .src2_is_8    (slot.src2_is_8),
        .result       (alu_result),
        .overflow     (alu_overflow)
    );

    mem_req_format u_fmt (
        .slot       (slot),
        .req        (fmt_req),
        .mem_addr   (mem_addr),
        .addr_error (addr_error),
        .is_store   (is_store)
    );

    assign is_mem = slot.mem_op != mem_none;
    assign ov_exc = slot.detect_overflow & alu_overflow;
    assign except = slot.valid & (slot.in_except | ov_exc | addr_error);

    // older exceptions win
    always_comb begin
        if (slot.in_except)            exccode = slot.in_exccode;
        else if (ov_exc)               exccode = exc_ov;
        else if (addr_error && !is_store) exccode = exc_adel;
        else if (addr_error)           exccode = exc_ades;
        else                           exccode = exc_none;
    end

    always_comb begin
        lane.result   = alu_result;
        lane.mem_addr = mem_addr;
        lane.except   = except;
        lane.exccode  = exccode;
        lane.badvaddr = slot.in_except ? slot.pc : mem_addr;
        lane.gr_we    = slot.gr_we;
        lane.dest     = slot.dest;
        lane.mem_op   = slot.mem_op;
        lane.valid    = slot.valid;
    end

    always_comb begin
        req       = fmt_req;
        req.valid = slot.valid & is_mem & ~except;
    end

endmodule

// ==== exe_pipe_ctrl.sv ====
`timescale 1ns/1ps

module exe_pipe_ctrl
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  issue_pair_t in_pair,
    input  logic        out_allowin,
    input  logic        flush,
    input  logic        all_done,
    input  lane_out_t   lane0,
    input  lane_out_t   lane1,
    output logic        allowin,
    output issue_slot_t slot0,
    output issue_slot_t slot1,
    output logic        stage_valid,
    output logic        load,
    output logic        ops_ready,
    output logic        out_valid,
    output stage_out_t  out_bus
);

    issue_pair_t     pair_r;
    logic            dep;
    logic            stall_done;
    logic [xlen-1:0] fwd_rs;
    logic [xlen-1:0] fwd_rt;

    assign load      = in_valid & allowin;
    assign out_valid = stage_valid & all_done;
    assign allowin   = ~stage_valid | (out_valid & out_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            stage_valid <= 1'b0;
        end else if (allowin) begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pair_r <= in_pair;
        end
    end

    // slot 1 reads slot 0's result
    assign dep = pair_r.slot1.valid & (pair_r.slot1.rs_dep | pair_r.slot1.rt_dep);

    // one bubble per dependent pair
    always_ff @(posedge clk) begin
        if (reset || flush || load) begin
            stall_done <= 1'b0;
        end else if (stage_valid && dep) begin
            stall_done <= 1'b1;
        end
    end

    // out_bus holds while the pair is offered downstream
    always_ff @(posedge clk) begin
        if (stage_valid && dep && !stall_done && !out_valid) begin
            if (pair_r.slot1.rs_dep) begin
                fwd_rs <= lane0.result;
            end
            if (pair_r.slot1.rt_dep) begin
                fwd_rt <= lane0.result;
            end
        end
    end

    assign ops_ready = ~dep | stall_done;

    always_comb begin
        slot0 = pair_r.slot0;
        slot1 = pair_r.slot1;
        if (pair_r.slot1.rs_dep) begin
            slot1.rs_value = fwd_rs;
        end
        if (pair_r.slot1.rt_dep) begin
            slot1.rt_value = fwd_rt;
        end
    end

    always_comb begin
        out_bus.lane0       = lane0;
        out_bus.lane1       = lane1;
        // a trap in either slot squashes slot 1
        out_bus.lane1.valid = lane1.valid & ~lane0.except & ~lane1.except;
    end

endmodule

// ==== exe_stage.f ====
ex_isa_pkg.sv
ex_bus_pkg.sv
exe_alu.sv
mem_req_format.sv
exe_lane.sv
exe_pipe_ctrl.sv
dcache_arbiter.sv
exe_stage.sv
exe_stage_asserts.sv
tb_exe_stage.sv

// ==== exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage
    import ex_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  issue_pair_t in_pair,
    output logic        allowin,
    output logic        out_valid,
    output stage_out_t  out_bus,
    input  logic        out_allowin,
    output dcache_req_t dcache_req,
    input  logic        dcache_addr_ok,
    input  logic        flush
);

    issue_slot_t slot0;
    issue_slot_t slot1;
    lane_out_t   lane0;
    lane_out_t   lane1;
    dcache_req_t req0;
    dcache_req_t req1;
    logic        stage_valid;
    logic        load;
    logic        ops_ready;
    logic        all_done;

    exe_pipe_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_pair     (in_pair),
        .out_allowin (out_allowin),
        .flush       (flush),
        .all_done    (all_done),
        .lane0       (lane0),
        .lane1       (lane1),
        .allowin     (allowin),
        .slot0       (slot0),
        .slot1       (slot1),
        .stage_valid (stage_valid),
        .load        (load),
        .ops_ready   (ops_ready),
        .out_valid   (out_valid),
        .out_bus     (out_bus)
    );

    exe_lane u_lane0 (
        .slot (slot0),
        .lane (lane0),
        .req  (req0)
    );

    exe_lane u_lane1 (
        .slot (slot1),
        .lane (lane1),
        .req  (req1)
    );

    // one cache port, lane 0 first
    dcache_arbiter u_arb (
        .clk          (clk),
        .reset        (reset),
        .stage_valid  (stage_valid),
        .load         (load),
        .ops_ready    (ops_ready),
        .flush        (flush),
        .req0         (req0),
        .req1         (req1),
        .lane0_except (lane0.except),
        .addr_ok      (dcache_addr_ok),
        .dcache_req   (dcache_req),
        .all_done     (all_done)
    );

endmodule

// ==== exe_stage_asserts.sv ====
`timescale 1ns/1ps

module exe_stage_asserts
    import ex_bus_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        flush,
    input logic        out_valid,
    input logic        out_allowin,
    input stage_out_t  out_bus,
    input dcache_req_t dcache_req,
    input logic        addr_ok
);

    int assert_fails = 0;

    // a flush may withdraw a pending request
    req_hold: assert property (@(posedge clk) disable iff (reset)
        dcache_req.valid && !addr_ok && !flush |=> dcache_req.valid && $stable(dcache_req))
        else begin
            assert_fails++;
            $error("cache request changed before addr_ok");
        end

    read_strobe: assert property (@(posedge clk) disable iff (reset)
        dcache_req.valid && !dcache_req.write |-> dcache_req.wstrb == 4'b0000)
        else begin
            assert_fails++;
            $error("read request with a nonzero strobe");
        end

    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin && !flush |=> out_valid && $stable(out_bus))
        else begin
            assert_fails++;
            $error("out_bus moved while stalled");
        end

    reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            assert_fails++;
            $error("out_valid high right after reset");
        end

endmodule

bind exe_stage exe_stage_asserts u_asserts (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .out_valid   (out_valid),
    .out_allowin (out_allowin),
    .out_bus     (out_bus),
    .dcache_req  (dcache_req),
    .addr_ok     (dcache_addr_ok)
);

// ==== mem_req_format.sv ====
`timescale 1ns/1ps

module mem_req_format
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
(
    input  issue_slot_t     slot,
    output dcache_req_t     req,
    output logic [xlen-1:0] mem_addr,
    output logic            addr_error,
    output logic            is_store
);

    logic            is_mem;
    logic [xlen-1:0] paddr;
    logic [1:0]      size;
    logic [3:0]      byte_strb;
    logic [3:0]      half_strb;
    logic [3:0]      wstrb;
    logic [xlen-1:0] wdata;

    assign is_mem   = slot.mem_op != mem_none;
    assign is_store = slot.mem_op inside {mem_sb, mem_sh, mem_sw};

    // base plus sign-extended offset
    assign mem_addr = slot.rs_value + {{(xlen-16){slot.imm16[15]}}, slot.imm16};

    // fixed mapping, segment bits stripped
    assign paddr = {3'b000, mem_addr[xlen-4:0]};

    always_comb begin
        case (slot.mem_op)
            mem_lb, mem_lbu, mem_sb: size = 2'd0;
            mem_lh, mem_lhu, mem_sh: size = 2'd1;
            default:                 size = 2'd2;
        endcase
    end

    assign byte_strb = 4'b0001 << mem_addr[1:0];
    assign half_strb = mem_addr[1] ? 4'b1100 : 4'b0011;

    // loads never write
    always_comb begin
        if (!is_store) begin
            wstrb = 4'b0000;
        end else begin
            case (size)
                2'd0:    wstrb = byte_strb;
                2'd1:    wstrb = half_strb;
                default: wstrb = 4'b1111;
            endcase
        end
    end

    // replicate so the cache picks lanes by strobe only
    always_comb begin
        case (size)
            2'd0:    wdata = {4{slot.rt_value[7:0]}};
            2'd1:    wdata = {2{slot.rt_value[15:0]}};
            default: wdata = slot.rt_value;
        endcase
    end

    assign addr_error = is_mem && ((size == 2'd1 && mem_addr[0]) ||
                                   (size == 2'd2 && mem_addr[1:0] != 2'b00));

    always_comb begin
        req         = '0;
        // valid is decided by the lane
        req.write   = is_store;
        req.uncache = mem_addr[xlen-1 -: 3] == uncache_seg;
        req.tag     = paddr[xlen-1 -: tag_w];
        req.index   = paddr[offset_w +: index_w];
        req.offset  = paddr[offset_w-1:0];
        req.size    = size;
        req.wstrb   = wstrb;
        req.wdata   = wdata;
    end

endmodule

// ==== tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;
;

    localparam int n_pairs    = 400;
    // worst case of about 12 cycles per pair
    localparam int max_cycles = n_pairs * 12;

    logic        clk;
    logic        reset;
    logic        in_valid;
    issue_pair_t in_pair;
    logic        allowin;
    logic        out_valid;
    stage_out_t  out_bus;
    logic        out_allowin;
    dcache_req_t dcache_req;
    logic        dcache_addr_ok;
    logic        flush;

    issue_pair_t pend_q[$];
    dcache_req_t exp_req_q[$];
    int          issued;
    int          retired;
    int          flushed;
    int          cycles;
    int          checks;
    int          errors;
    int          ok_wait;

    exe_stage uut (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_pair        (in_pair),
        .allowin        (allowin),
        .out_valid      (out_valid),
        .out_bus        (out_bus),
        .out_allowin    (out_allowin),
        .dcache_req     (dcache_req),
        .dcache_addr_ok (dcache_addr_ok),
        .flush          (flush)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic issue_slot_t random_slot(input bit second);
        issue_slot_t s;
        s = '0;
        s.valid = second ? ($urandom_range(0, 3) != 0) : 1'b1;
        s.pc = $urandom & 32'hffff_fffc;
        s.imm16 = 16'($urandom);
        s.alu_op = alu_op_t'($urandom_range(0, 13));
        case ($urandom_range(0, 3))
            0: s.src1_is_sa = 1'b1;
            1: s.src1_is_pc = 1'b1;
            default: ;
        endcase
        case ($urandom_range(0, 4))
            0: s.src2_is_simm = 1'b1;
            1: s.src2_is_zimm = 1'b1;
            2: s.src2_is_8 = 1'b1;
            default: ;
        endcase
        s.detect_overflow = 1'($urandom);
        s.mem_op = $urandom_range(0, 1) ? mem_op_t'($urandom_range(1, 8)) : mem_none;
        s.gr_we = 1'($urandom);
        s.dest = 5'($urandom);
        s.rs_value = $urandom;
        s.rt_value = $urandom;
        if (s.mem_op inside {mem_lh, mem_lhu, mem_sh, mem_lw, mem_sw} &&
            $urandom_range(0, 3) != 0) begin
            // mostly aligned so that most requests reach the cache
            s.rs_value[1:0] = 2'b00;
            s.imm16[0] = 1'b0;
            if (s.mem_op inside {mem_lw, mem_sw}) begin
                s.imm16[1] = 1'b0;
            end
        end
        s.in_except = ($urandom_range(0, 15) == 0);
        s.in_exccode = exccode_t'($urandom_range(1, 31));
        if (second && s.valid) begin
            s.rs_dep = ($urandom_range(0, 3) == 0);
            s.rt_dep = ($urandom_range(0, 3) == 0);
        end
        return s;
    endfunction

    function automatic logic [31:0] operand_a(input issue_slot_t s);
        if (s.src1_is_sa) return {27'b0, s.imm16[10:6]};
        if (s.src1_is_pc) return s.pc;
        return s.rs_value;
    endfunction

    function automatic logic [31:0] operand_b(input issue_slot_t s);
        if (s.src2_is_simm) return {{16{s.imm16[15]}}, s.imm16};
        if (s.src2_is_zimm) return {16'b0, s.imm16};
        if (s.src2_is_8) return 32'd8;
        return s.rt_value;
    endfunction

    function automatic logic [31:0] alu_model(input issue_slot_t s);
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] ext;
        a = operand_a(s);
        b = operand_b(s);
        ext = {{32{b[31]}}, b} >> a[4:0];
        case (s.alu_op)
            alu_add, alu_addu: return a + b;
            alu_sub, alu_subu: return a - b;
            alu_and:           return a & b;
            alu_or:            return a | b;
            alu_xor:           return a ^ b;
            alu_nor:           return ~(a | b);
            alu_slt:           return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu:          return (a < b) ? 32'd1 : 32'd0;
            alu_sll:           return b << a[4:0];
            alu_srl:           return b >> a[4:0];
            alu_sra:           return ext[31:0];
            alu_lui:           return {b[15:0], 16'h0000};
            default:           return 32'd0;
        endcase
    endfunction

    // overflow when the top two bits of the 33-bit result differ
    function automatic bit overflow_model(input issue_slot_t s);
        logic [31:0] x;
        logic [31:0] y;
        logic [32:0] a;
        logic [32:0] b;
        logic [32:0] r;
        x = operand_a(s);
        y = operand_b(s);
        a = {x[31], x};
        b = {y[31], y};
        if (s.alu_op == alu_add) r = a + b;
        else if (s.alu_op == alu_sub) r = a - b;
        else return 1'b0;
        return r[32] != r[31];
    endfunction

    function automatic logic [31:0] addr_model(input issue_slot_t s);
        return s.rs_value + {{16{s.imm16[15]}}, s.imm16};
    endfunction

    function automatic logic [1:0] size_model(input mem_op_t m);
        if (m inside {mem_lb, mem_lbu, mem_sb}) return 2'd0;
        if (m inside {mem_lh, mem_lhu, mem_sh}) return 2'd1;
        return 2'd2;
    endfunction

    function automatic bit misaligned(input issue_slot_t s);
        logic [31:0] a;
        a = addr_model(s);
        if (s.mem_op == mem_none) return 1'b0;
        if (size_model(s.mem_op) == 2'd1) return a[0];
        if (size_model(s.mem_op) == 2'd2) return a[1:0] != 2'b00;
        return 1'b0;
    endfunction

    function automatic lane_out_t lane_model(input issue_slot_t s);
        lane_out_t e;
        bit        ov;
        bit        ae;
        bit        store;
        e = '0;
        ov = s.detect_overflow && overflow_model(s);
        ae = misaligned(s);
        store = s.mem_op inside {mem_sb, mem_sh, mem_sw};
        e.result = alu_model(s);
        e.mem_addr = addr_model(s);
        e.except = s.valid && (s.in_except || ov || ae);
        if (s.in_except) e.exccode = s.in_exccode;
        else if (ov) e.exccode = exc_ov;
        else if (ae) e.exccode = store ? exc_ades : exc_adel;
        e.badvaddr = s.in_except ? s.pc : e.mem_addr;
        e.gr_we = s.gr_we;
        e.dest = s.dest;
        e.mem_op = s.mem_op;
        e.valid = s.valid;
        return e;
    endfunction

    function automatic dcache_req_t req_model(input issue_slot_t s);
        dcache_req_t r;
        logic [31:0] a;
        logic [31:0] pa;
        r = '0;
        a = addr_model(s);
        // physical address keeps the low 29 bits
        pa = {3'b000, a[28:0]};
        r.valid = 1'b1;
        r.write = s.mem_op inside {mem_sb, mem_sh, mem_sw};
        r.uncache = (a[31:29] == 3'b101);
        r.tag = pa[31:12];
        r.index = pa[11:5];
        r.offset = pa[4:0];
        r.size = size_model(s.mem_op);
        case (r.size)
            2'd0: r.wdata = {4{s.rt_value[7:0]}};
            2'd1: r.wdata = {2{s.rt_value[15:0]}};
            default: r.wdata = s.rt_value;
        endcase
        if (r.write) begin
            case (r.size)
                2'd0: r.wstrb = 4'b0001 << a[1:0];
                2'd1: r.wstrb = a[1] ? 4'b1100 : 4'b0011;
                default: r.wstrb = 4'b1111;
            endcase
        end
        return r;
    endfunction

    // slot 1 as the lane sees it once the dependency is resolved
    function automatic issue_slot_t resolved_slot1(input issue_pair_t p);
        issue_slot_t s;
        s = p.slot1;
        if (s.rs_dep) s.rs_value = alu_model(p.slot0);
        if (s.rt_dep) s.rt_value = alu_model(p.slot0);
        return s;
    endfunction

    task automatic queue_requests(input issue_pair_t p);
        lane_out_t   e0;
        lane_out_t   e1;
        issue_slot_t s1;
        e0 = lane_model(p.slot0);
        s1 = resolved_slot1(p);
        e1 = lane_model(s1);
        if (p.slot0.valid && p.slot0.mem_op != mem_none && !e0.except) begin
            exp_req_q.push_back(req_model(p.slot0));
        end
        if (!e0.except && s1.valid && s1.mem_op != mem_none && !e1.except) begin
            exp_req_q.push_back(req_model(s1));
        end
    endtask

    task automatic check_request(input dcache_req_t got);
        dcache_req_t exp;
        if (exp_req_q.size() == 0) begin
            errors++;
            $display("unexpected data cache request at %0t", $time);
        end else begin
            exp = exp_req_q.pop_front();
            check(got.write, exp.write, "req write");
            check(got.tag, exp.tag, "req tag");
            check(got.index, exp.index, "req index");
            check(got.offset, exp.offset, "req offset");
            check(got.size, exp.size, "req size");
            check(got.wstrb, exp.wstrb, "req wstrb");
            check(got.wdata, exp.wdata, "req wdata");
            check(got.uncache, exp.uncache, "req uncache");
        end
    endtask

    task automatic check_lane(input lane_out_t got, input lane_out_t exp, input string name);
        check(got.result, exp.result, {name, " result"});
        check(got.mem_addr, exp.mem_addr, {name, " mem_addr"});
        check(got.dest, exp.dest, {name, " dest"});
        check(got.gr_we, exp.gr_we, {name, " gr_we"});
        check(got.mem_op, exp.mem_op, {name, " mem_op"});
        check(got.except, exp.except, {name, " except"});
        if (exp.except) begin
            check(got.exccode, exp.exccode, {name, " exccode"});
            check(got.badvaddr, exp.badvaddr, {name, " badvaddr"});
        end
    endtask

    task automatic check_pair(input issue_pair_t p);
        lane_out_t e0;
        lane_out_t e1;
        e0 = lane_model(p.slot0);
        e1 = lane_model(resolved_slot1(p));
        check(out_bus.lane0.valid, e0.valid, "lane0 valid");
        if (e0.valid) begin
            check_lane(out_bus.lane0, e0, "lane0");
        end
        check(out_bus.lane1.valid, e1.valid && !e0.except && !e1.except, "lane1 valid");
        // a lane 0 trap squashes lane 1 and leaves its fields undefined
        if (e1.valid && !e0.except) begin
            check_lane(out_bus.lane1, e1, "lane1");
        end
    endtask

    // samples at the rising edge and drives the next cycle
    task automatic step();
        bit next_flush;
        if (dcache_req.valid) begin
            if (dcache_addr_ok) begin
                check_request(dcache_req);
                ok_wait = $urandom_range(0, 3);
            end else if (ok_wait > 0) begin
                ok_wait--;
            end
        end
        if (out_valid && out_allowin) begin
            if (pend_q.size() == 0) begin
                errors++;
                $display("output at %0t with no pair in the stage", $time);
            end else begin
                check_pair(pend_q.pop_front());
                if (exp_req_q.size() != 0) begin
                    errors++;
                    $display("pair left at %0t with cache requests missing", $time);
                end
                exp_req_q.delete();
                retired++;
            end
        end
        if (flush) begin
            retired += pend_q.size();
            flushed += pend_q.size();
            pend_q.delete();
            exp_req_q.delete();
        end else if (in_valid && allowin) begin
            pend_q.push_back(in_pair);
            queue_requests(in_pair);
            issued++;
        end
        next_flush = ($urandom_range(0, 63) == 0);
        flush <= next_flush;
        in_valid <= !next_flush && issued < n_pairs && ($urandom_range(0, 3) != 0);
        in_pair <= '{slot0: random_slot(1'b0), slot1: random_slot(1'b1)};
        out_allowin <= ($urandom_range(0, 3) != 0);
        dcache_addr_ok <= (ok_wait == 0);
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_pair = '0;
        out_allowin = 1'b0;
        dcache_addr_ok = 1'b0;
        flush = 1'b0;
        issued = 0;
        retired = 0;
        flushed = 0;
        cycles = 0;
        checks = 0;
        errors = 0;
        ok_wait = 0;
        void'($urandom(32'h8e2c_c5fd));
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (retired < n_pairs && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
            step();
        end
        if (retired < n_pairs) begin
            errors++;
            $display("timeout: only %0d of %0d pairs left the stage in %0d cycles",
                     retired, n_pairs, max_cycles);
        end
        $display("pairs %0d, flushed %0d, checks %0d, errors %0d, assertion failures %0d",
                 retired, flushed, checks, errors, uut.u_asserts.assert_fails);
        if (errors == 0 && uut.u_asserts.assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
